/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/icache.sv */
`default_nettype none

// direct-mapped instruction cache returning a 48-bit fetch window
module icache
   import icache_pkg::*;
#(
   parameter int SET_BITS = 8
)
(
   input  logic        clk_i,
   input  logic        rst_i,
   // fetch request
   input  logic [31:0] adr_i,
   input  logic        stb_i,
   output logic        hit_o,
   output logic [15:0] inst_o,
   output logic [31:0] data_o,
   // memory bus
   output logic [31:0] wb_adr_o,
   output logic [1:0]  wb_sel_o,
   output logic        wb_cyc_o,
   output logic        wb_stb_o,
   input  logic [15:0] wb_dat_i,
   input  logic        wb_ack_i
);

   localparam int TAG_BITS = 27 - SET_BITS;

   // lookup wiring between the controller and the stores
   logic [SET_BITS-1:0]      first_set;
   logic [TAG_BITS-1:0]      first_tag;
   logic [SET_BITS-1:0]      second_set;
   logic [TAG_BITS-1:0]      second_tag;
   logic [WORD_OFS_BITS-1:0] word;
   logic                     hit_first;
   logic                     hit_second;

   // refill write path
   line_fill_if #(.SET_BITS(SET_BITS)) u_fill ();

   tag_store #(.SET_BITS(SET_BITS)) u_tags (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fill         (u_fill),
      .first_set_i  (first_set),
      .first_tag_i  (first_tag),
      .second_set_i (second_set),
      .second_tag_i (second_tag),
      .hit_first_o  (hit_first),
      .hit_second_o (hit_second)
   );

   line_store #(.SET_BITS(SET_BITS)) u_lines (
      .clk_i       (clk_i),
      .fill        (u_fill),
      .first_set_i (first_set),
      .word_i      (word),
      .inst_o      (inst_o),
      .data_o      (data_o)
   );

   refill_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .adr_i        (adr_i),
      .stb_i        (stb_i),
      .hit_first_i  (hit_first),
      .hit_second_i (hit_second),
      .first_set_o  (first_set),
      .first_tag_o  (first_tag),
      .second_set_o (second_set),
      .second_tag_o (second_tag),
      .word_o       (word),
      .hit_o        (hit_o),
      .fill         (u_fill),
      .wb_adr_o     (wb_adr_o),
      .wb_sel_o     (wb_sel_o),
      .wb_cyc_o     (wb_cyc_o),
      .wb_stb_o     (wb_stb_o),
      .wb_dat_i     (wb_dat_i),
      .wb_ack_i     (wb_ack_i)
   );

endmodule

`default_nettype wire

/* rtl/icache_pkg.sv */
`default_nettype none

package icache_pkg;

   // line geometry: 32 bytes per line, fetched as 16 halfwords
   localparam int LINE_BYTES    = 32;
   localparam int LINE_WORDS    = LINE_BYTES / 2;
   // halfword offset within one line
   localparam int WORD_OFS_BITS = $clog2(LINE_WORDS);

   // byte address of a fetch, seen either as one word or as its fields
   // tttttttttttttttttttssssssssoooob
   // field widths are laid out for the default of 8 set bits
   typedef union packed
   {
      // plain byte address, used for bus address and line stepping
      logic [31:0] raw;
      struct packed
      {
         // tag above the set index
         logic [18:0] tag;
         // direct-mapped set index
         logic [7:0]  set;
         // halfword within the line
         logic [WORD_OFS_BITS-1:0] word;
         // byte within the halfword, always 0 for aligned fetches
         logic        byte_sel;
      } fields;
   } fetch_addr_t;

   // refill FSM encoding
   typedef enum logic [2:0]
   {
      // no burst on the bus, hit/miss checked every cycle
      IDLE        = 3'd0,
      // filling the line that holds the instruction parcel
      FILL_FIRST  = 3'd1,
      // filling the following line for a window that crosses over
      FILL_SECOND = 3'd2
   } refill_state_e;

endpackage

`default_nettype wire

/* rtl/line_fill_if.sv */
`default_nettype none

// one halfword refill write, shared by the tag store and the line store
interface line_fill_if
   import icache_pkg::*;
#(
   parameter int SET_BITS = 8
)
();

   localparam int TAG_BITS = 27 - SET_BITS;

   // strobe for one halfword
   logic                     wr_en;
   // destination set and halfword slot
   logic [SET_BITS-1:0]      wr_set;
   logic [WORD_OFS_BITS-1:0] wr_word;
   logic [15:0]              wr_data;
   // high together with wr_en on the last halfword of the line
   logic                     line_done;
   // tag committed to the tag store on line_done
   logic [TAG_BITS-1:0]      line_tag;

   // refill controller side
   modport ctrl (output wr_en, wr_set, wr_word, wr_data, line_done, line_tag);

   // both storage arrays
   modport store (input wr_en, wr_set, wr_word, wr_data, line_done, line_tag);

endinterface

`default_nettype wire

/* rtl/line_store.sv */
`default_nettype none

module line_store
   import icache_pkg::*;
#(
   parameter int SET_BITS = 8
)
(
   input  logic                     clk_i,
   line_fill_if.store               fill,
   input  logic [SET_BITS-1:0]      first_set_i,
   input  logic [WORD_OFS_BITS-1:0] word_i,
   output logic [15:0]              inst_o,
   output logic [31:0]              data_o
);

   // flat halfword index is {set, word}
   localparam int IDX_BITS  = SET_BITS + WORD_OFS_BITS;
   localparam int NUM_WORDS = (1 << SET_BITS) * LINE_WORDS;

   // halfword array, no reset
   logic [15:0] mem [NUM_WORDS];

   // read indices for the three parcels of the window
   logic [IDX_BITS-1:0] idx_inst;
   logic [IDX_BITS-1:0] idx_hi;
   logic [IDX_BITS-1:0] idx_lo;

   // one halfword per acked bus beat
   always_ff @(posedge clk_i)
   begin
      if (fill.wr_en)
      begin
         mem[{fill.wr_set, fill.wr_word}] <= fill.wr_data;
      end
   end

   assign idx_inst = {first_set_i, word_i};
   // carry out of the word field moves into the next set
   // and the top set wraps back to set 0
   assign idx_hi   = idx_inst + IDX_BITS'(1);
   assign idx_lo   = idx_inst + IDX_BITS'(2);

   // instruction parcel
   assign inst_o = mem[idx_inst];

   // immediate, upper half comes first in memory
   assign data_o = {mem[idx_hi], mem[idx_lo]};

endmodule

`default_nettype wire

/* rtl/refill_ctrl.sv */
`default_nettype none

module refill_ctrl
   import icache_pkg::*;
#(
   parameter int SET_BITS = 8
)
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   // fetch side
   input  logic [31:0]              adr_i,
   input  logic                     stb_i,
   input  logic                     hit_first_i,
   input  logic                     hit_second_i,
   output logic [SET_BITS-1:0]      first_set_o,
   output logic [26-SET_BITS:0]     first_tag_o,
   output logic [SET_BITS-1:0]      second_set_o,
   output logic [26-SET_BITS:0]     second_tag_o,
   output logic [WORD_OFS_BITS-1:0] word_o,
   output logic                     hit_o,
   // refill writes into both stores
   line_fill_if.ctrl                fill,
   // memory bus master
   output logic [31:0]              wb_adr_o,
   output logic [1:0]               wb_sel_o,
   output logic                     wb_cyc_o,
   output logic                     wb_stb_o,
   input  logic [15:0]              wb_dat_i,
   input  logic                     wb_ack_i
);

   localparam int TAG_BITS   = 27 - SET_BITS;
   localparam int LINE_SHIFT = $clog2(LINE_BYTES);

   // fetch address and line-aligned forms of it
   fetch_addr_t fetch_adr;
   fetch_addr_t line_base;
   fetch_addr_t next_base;

   // window runs past the end of the current line
   logic needs_second;
   // last halfword of the burst is being acked
   logic last_beat;

   refill_state_e            state;
   logic [WORD_OFS_BITS-1:0] beat;
   // target of the burst in progress
   logic [SET_BITS-1:0]      fill_set;
   logic [TAG_BITS-1:0]      fill_tag;

   always_comb
   begin
      fetch_adr.raw = adr_i;
      // clear the offset fields to get the start of the line
      line_base                 = fetch_adr;
      line_base.fields.word     = '0;
      line_base.fields.byte_sel = 1'b0;
      // step a whole line so a carry out of the set reaches the tag
      next_base.raw = line_base.raw + 32'(LINE_BYTES);
   end

   // set and tag are sliced by SET_BITS since the union fields assume 8
   assign first_set_o  = line_base.raw[LINE_SHIFT +: SET_BITS];
   assign first_tag_o  = line_base.raw[LINE_SHIFT + SET_BITS +: TAG_BITS];
   assign second_set_o = next_base.raw[LINE_SHIFT +: SET_BITS];
   assign second_tag_o = next_base.raw[LINE_SHIFT + SET_BITS +: TAG_BITS];
   assign word_o       = fetch_adr.fields.word;

   // offsets 14 and 15 pull parcels from the following line
   assign needs_second = fetch_adr.fields.word >= WORD_OFS_BITS'(LINE_WORDS - 2);

   // zero latency hit held low while reset is asserted
   assign hit_o = !rst_i && hit_first_i && (!needs_second || hit_second_i);

   assign wb_cyc_o  = wb_stb_o;
   assign last_beat = (beat == WORD_OFS_BITS'(LINE_WORDS - 1));

   // every acked halfword goes straight into the stores
   assign fill.wr_en     = wb_stb_o && wb_ack_i;
   assign fill.wr_set    = fill_set;
   assign fill.wr_word   = beat;
   assign fill.wr_data   = wb_dat_i;
   assign fill.line_done = wb_stb_o && wb_ack_i && last_beat;
   assign fill.line_tag  = fill_tag;

   // burst target
   always_ff @(posedge clk_i)
   begin
      if (state == IDLE)
      begin
         // first line takes priority and the second is only picked once it hits
         if (!hit_first_i)
         begin
            fill_set <= first_set_o;
            fill_tag <= first_tag_o;
            wb_adr_o <= line_base.raw;
         end
         else
         begin
            fill_set <= second_set_o;
            fill_tag <= second_tag_o;
            wb_adr_o <= next_base.raw;
         end
      end
      else if (wb_ack_i)
      begin
         // next halfword of the line
         wb_adr_o <= wb_adr_o + 32'd2;
      end
   end

   // refill FSM
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state    <= IDLE;
         beat     <= '0;
         wb_stb_o <= 1'b0;
         wb_sel_o <= 2'b00;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               beat <= '0;
               if (stb_i && !hit_first_i)
               begin
                  state    <= FILL_FIRST;
                  wb_stb_o <= 1'b1;
                  wb_sel_o <= 2'b11;
               end
               else if (stb_i && needs_second && !hit_second_i)
               begin
                  // second line follows one idle cycle after the first
                  state    <= FILL_SECOND;
                  wb_stb_o <= 1'b1;
                  wb_sel_o <= 2'b11;
               end
            end

            FILL_FIRST, FILL_SECOND:
            begin
               // strobe stays up for all 16 beats and waits for ack without limit
               if (wb_ack_i)
               begin
                  beat <= beat + WORD_OFS_BITS'(1);
                  if (last_beat)
                  begin
                     state    <= IDLE;
                     wb_stb_o <= 1'b0;
                     wb_sel_o <= 2'b00;
                  end
               end
            end

            default:
            begin
               state    <= IDLE;
               wb_stb_o <= 1'b0;
               wb_sel_o <= 2'b00;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/tag_store.sv */
`default_nettype none

module tag_store
#(
   parameter int SET_BITS = 8
)
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   line_fill_if.store               fill,
   input  logic [SET_BITS-1:0]      first_set_i,
   input  logic [26-SET_BITS:0]     first_tag_i,
   input  logic [SET_BITS-1:0]      second_set_i,
   input  logic [26-SET_BITS:0]     second_tag_i,
   output logic                     hit_first_o,
   output logic                     hit_second_o
);

   localparam int TAG_BITS = 27 - SET_BITS;
   localparam int NUM_SETS = 1 << SET_BITS;

   // one valid bit per set, kept in flops so reset can clear them all
   logic [NUM_SETS-1:0] valid;
   // tag array
   logic [TAG_BITS-1:0] tags [NUM_SETS];

   // set written by a refill that has just delivered its last halfword
   logic                commit;

   assign commit = fill.wr_en && fill.line_done;

   // valid bits
   // a set only becomes valid once its own line is complete
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         valid <= '0;
      end
      else if (commit)
      begin
         valid[fill.wr_set] <= 1'b1;
      end
   end

   // tags are written in the same cycle the valid bit is set
   always_ff @(posedge clk_i)
   begin
      if (commit)
      begin
         tags[fill.wr_set] <= fill.line_tag;
      end
   end

   // lookup for the line holding the instruction parcel
   assign hit_first_o = valid[first_set_i] && (tags[first_set_i] == first_tag_i);

   // lookup for the following line
   // the controller only uses it when the window crosses over
   assign hit_second_o = valid[second_set_i] && (tags[second_set_i] == second_tag_i);

endmodule

`default_nettype wire

/* sim.f */
rtl/icache_pkg.sv
rtl/line_fill_if.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/refill_ctrl.sv
rtl/icache.sv
testbench/icache_assert.sv
testbench/wb_mem_model.sv
testbench/icache_tb.sv

/* testbench/icache_assert.sv */
`default_nettype none

// bus and hit protocol properties bound into the cache top level
module icache_assert
   import icache_pkg::*;
(
   input logic          clk_i,
   input logic          rst_i,
   input logic          hit_i,
   input logic          wb_cyc_i,
   input logic          wb_stb_i,
   input logic [31:0]   wb_adr_i,
   input logic          wb_ack_i,
   input refill_state_e state_i
);

   // failed assertions so far
   int fail_count;

   initial
   begin
      fail_count = 0;
   end

   // cycle and strobe are one signal on this bus
   a_cyc_is_stb: assert property (@(posedge clk_i) wb_cyc_i == wb_stb_i)
   else
   begin
      fail_count++;
      $error("wb_cyc_o differs from wb_stb_o");
   end

   // first cycle out of reset has an idle bus and an idle FSM
   a_idle_after_reset: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !wb_stb_i && state_i == IDLE)
   else
   begin
      fail_count++;
      $error("bus or FSM not idle after reset");
   end

   // address holds while a beat waits for its ack
   a_adr_held: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i))
   else
   begin
      fail_count++;
      $error("wb_adr_o moved without an ack");
   end

   // no hit reported while a line is still being refilled
   a_no_hit_in_fill: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_cyc_i |-> !hit_i)
   else
   begin
      fail_count++;
      $error("hit_o high during a bus cycle");
   end

endmodule

bind icache icache_assert u_assert (
   .clk_i    (clk_i),
   .rst_i    (rst_i),
   .hit_i    (hit_o),
   .wb_cyc_i (wb_cyc_o),
   .wb_stb_i (wb_stb_o),
   .wb_adr_i (wb_adr_o),
   .wb_ack_i (wb_ack_i),
   .state_i  (u_ctrl.state)
);

`default_nettype wire

/* testbench/icache_cases.txt */
// columns: op_address_fills, op 1 = fetch, 2 = reset, 0 = end of list
// fills is the expected number of line fills for the fetch (hex)
1_00000100_01
1_00000100_00
1_0000011A_00
1_0000015C_02
1_0000017E_01
1_00002100_01
1_00000104_01
1_00001FFC_02
1_00002004_00
1_00000004_01
2_00000000_00
1_00000100_01
1_00000100_00
// end of list follows from the zero fill of the case array

/* testbench/icache_tb.sv */
`default_nettype none

module icache_tb;

   localparam int MAX_CASES = 32;
   localparam int HIT_TIMEOUT = 400;

   logic        clk_i;
   logic        rst_i;
   logic [31:0] adr_i;
   logic        stb_i;
   logic        hit_o;
   logic [15:0] inst_o;
   logic [31:0] data_o;
   logic [31:0] wb_adr_o;
   logic [1:0]  wb_sel_o;
   logic        wb_cyc_o;
   logic        wb_stb_o;
   logic [15:0] wb_dat_i;
   logic        wb_ack_i;
   // completed lines counted by the memory model
   logic [31:0] lines;

   // op, address, expected fills packed per case
   logic [43:0] cases [MAX_CASES];

   int mismatches;
   int timeouts;
   int other_errors;
   // rising edges of wb_stb_o seen on the bus
   int bursts = 0;
   logic stb_q;

   icache #(.SET_BITS(8)) dut (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .adr_i    (adr_i),
      .stb_i    (stb_i),
      .hit_o    (hit_o),
      .inst_o   (inst_o),
      .data_o   (data_o),
      .wb_adr_o (wb_adr_o),
      .wb_sel_o (wb_sel_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_dat_i (wb_dat_i),
      .wb_ack_i (wb_ack_i)
   );

   wb_mem_model u_mem (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_adr_i (wb_adr_o),
      .wb_cyc_i (wb_cyc_o),
      .wb_stb_i (wb_stb_o),
      .wb_dat_o (wb_dat_i),
      .wb_ack_o (wb_ack_i),
      .lines_o  (lines)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // each burst start is one line fill on the bus
   always @(posedge clk_i)
   begin
      stb_q <= wb_stb_o;
      if (wb_stb_o && !stb_q)
      begin
         bursts <= bursts + 1;
      end
   end

   // parcel at byte address a is its halfword index xor a fixed mask
   function automatic logic [15:0] expected_parcel(input logic [31:0] a);
      return a[16:1] ^ 16'hA5C3;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
         mismatches++;
      end
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      rst_i <= 1'b1;
      stb_i <= 1'b0;
      repeat (2) @(posedge clk_i);
      rst_i <= 1'b0;
   endtask

   // hold the fetch until hit_o and then check the window and the fill count
   task automatic run_fetch(input logic [31:0] adr, input int fills);
      int cycles;
      bit seen;
      logic [31:0] lines_start;
      int bursts_start;
      lines_start  = lines;
      bursts_start = bursts;
      cycles       = 0;
      seen         = 1'b0;
      @(posedge clk_i);
      adr_i <= adr;
      stb_i <= 1'b1;
      // outputs are sampled mid cycle
      while (!seen && cycles < HIT_TIMEOUT)
      begin
         @(negedge clk_i);
         // both byte lanes are read on every beat
         if (wb_stb_o)
         begin
            check_value(32'(wb_sel_o), 32'h3, "wb_sel_o");
         end
         if (hit_o)
         begin
            seen = 1'b1;
         end
         else
         begin
            cycles++;
         end
      end
      if (!seen)
      begin
         $display("timeout: fetch at %h got no hit within %0d cycles", adr, HIT_TIMEOUT);
         timeouts++;
      end
      else
      begin
         check_value(32'(inst_o), 32'(expected_parcel(adr)), "inst_o");
         check_value(data_o, {expected_parcel(adr + 32'd2), expected_parcel(adr + 32'd4)},
                     "data_o");
         check_value(lines - lines_start, 32'(fills), "line fills");
         check_value(32'(bursts - bursts_start), 32'(fills), "bus bursts");
      end
      @(posedge clk_i);
      stb_i <= 1'b0;
   endtask

   initial
   begin
      int idx;
      bit done;
      logic [3:0] op;
      int asserts;
      rst_i        = 1'b1;
      stb_i        = 1'b0;
      adr_i        = '0;
      mismatches   = 0;
      timeouts     = 0;
      other_errors = 0;
      idx          = 0;
      done         = 1'b0;
      for (int i = 0; i < MAX_CASES; i++)
      begin
         cases[i] = '0;
      end
      $readmemh("testbench/icache_cases.txt", cases);
      if (cases[0][43:40] == 4'h0)
      begin
         $display("the cases file is missing or holds no cases");
         other_errors++;
      end
      apply_reset();
      // stop replaying after a timeout since the cache is stuck
      while (idx < MAX_CASES && !done && timeouts == 0)
      begin
         op = cases[idx][43:40];
         case (op)
            4'h0: done = 1'b1;
            4'h1: run_fetch(cases[idx][39:8], int'(cases[idx][7:0]));
            4'h2: apply_reset();
            default:
            begin
               $display("case %0d has an unknown operation %h", idx, op);
               other_errors++;
            end
         endcase
         idx++;
      end
      asserts = dut.u_assert.fail_count;
      $display("%0d mismatches, %0d timeouts, %0d other errors, %0d assertion failures",
               mismatches, timeouts, other_errors, asserts);
      if (mismatches + timeouts + other_errors + asserts == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/wb_mem_model.sv */
`default_nettype none

// 16-bit bus slave with a computed memory image and a random ack delay
module wb_mem_model
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [31:0] wb_adr_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   output logic [15:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic [31:0] lines_o
);

   // wait states left before the next ack
   logic [1:0] wait_cnt;
   // acked halfwords within the current line
   logic [3:0] beat_cnt;

   // memory image, halfword index folded with a constant
   function automatic logic [15:0] mem_halfword(input logic [31:0] adr);
      return adr[16:1] ^ 16'hA5C3;
   endfunction

   // one seed for the whole run
   initial
   begin
      void'($urandom(32'h98350c19));
   end

   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
         wait_cnt <= 2'($urandom % 4);
         beat_cnt <= '0;
         lines_o  <= '0;
      end
      else if (wb_ack_o)
      begin
         // master takes the halfword on this edge
         wb_ack_o <= 1'b0;
         wait_cnt <= 2'($urandom % 4);
         beat_cnt <= beat_cnt + 4'd1;
         // sixteenth beat closes a line
         if (beat_cnt == 4'd15)
         begin
            lines_o <= lines_o + 32'd1;
         end
      end
      else if (wb_cyc_i && wb_stb_i)
      begin
         if (wait_cnt == 2'd0)
         begin
            wb_ack_o <= 1'b1;
            wb_dat_o <= mem_halfword(wb_adr_i);
         end
         else
         begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire
